// File: src.f
+incdir+source
source/csr_pkg.sv
source/fml_pkg.sv
source/memtest_prng.sv
source/memtest_regs.sv
source/memtest_engine.sv
source/memtest_checker.sv
source/memtest.sv
testbench/memtest_fml_model.sv
testbench/memtest_tb.sv

// File: testbench/memtest_tb.sv
/*
 * Memory tester testbench.
 * Clock and reset, CSR access tasks, reference generators,
 * directed tests, the watchdog and the closing report.
 */

`timescale 1ns/100ps
`default_nettype none

`include "memtest_macros.svh"

module memtest_tb;

	import csr_pkg::*;
	import fml_pkg::*;

	localparam int NB = 24; // bursts per pass.
	localparam int MAX_DELAY = 7; // extra ack cycles under back-pressure.
	localparam int PASSES = 5; // passes that move bursts.
	localparam int WATCHDOG_NS = PASSES * NB * (`MEMTEST_BURST_LEN + MAX_DELAY) * 4 + 2000;
	localparam csr_data_t ADDRESS_VALUE = 32'h0200_0000; // sets the top address bit.
	localparam logic [3:0] BANK = `MEMTEST_CSR_BANK;
	localparam logic [3:0] OTHER = `MEMTEST_CSR_BANK ^ 4'h5; // a bank that must not decode.

	logic sys_clk = 1'b0;
	logic sys_rst;
	csr_addr_t csr_a;
	logic csr_we;
	csr_data_t csr_di;
	csr_data_t csr_do;
	fml_adr_t fml_adr;
	logic fml_stb;
	logic fml_we;
	logic fml_ack;
	fml_word_t fml_di;
	fml_sel_t fml_sel;
	fml_word_t fml_do;
	logic [2:0] delay_cycles;

	logic [31:0] lfsr = 32'h41b599fc; // stimulus state.
	int errors = 0;
	int tests = 0;
	int failed = 0;
	int test_errors = 0; // errors before the running test.

	always #2 sys_clk = ~sys_clk; // 4 ns period.

	memtest UUT (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we), .fml_ack(fml_ack),
		.fml_di(fml_di), .fml_sel(fml_sel), .fml_do(fml_do)
	);

	memtest_fml_model fml_mem (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.fml_adr(fml_adr), .fml_stb(fml_stb), .fml_we(fml_we), .fml_ack(fml_ack),
		.fml_di(fml_di), .fml_do(fml_do), .delay_cycles(delay_cycles)
	);

	// ------------------------------------------------------------------------
	// reference sequences and stimulus
	// ------------------------------------------------------------------------
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32,22,2,1.
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic adr_rand_t next_adr(input adr_rand_t s);
		return {s[18:0], s[19] ^ s[16]}; // taps 20,17.
	endfunction

	function automatic fml_word_t next_data(input fml_word_t s);
		return {s[62:0], s[63] ^ s[62] ^ s[60] ^ s[59]}; // taps 64,63,61,60.
	endfunction

	function automatic adr_rand_t burst_index(input int n);
		adr_rand_t s;
		s = `MEMTEST_ADR_SEED; // reloaded by each address write.
		repeat (n) s = next_adr(s);
		return s;
	endfunction

	function automatic csr_addr_t reg_addr(input logic [3:0] bank, input reg_index_t off);
		return {bank, 7'd0, off};
	endfunction

	// ------------------------------------------------------------------------
	// reporting and CSR access
	// ------------------------------------------------------------------------
	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		$display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("error at %0d ns: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != test_errors) begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - test_errors);
		end else
			$display("test %s: ok", name);
		test_errors = errors;
	endtask

	task automatic csr_write(input csr_addr_t a, input csr_data_t d);
		@(posedge sys_clk);
		#1;
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we = 1'b0;
	endtask

	task automatic csr_read(input csr_addr_t a, output csr_data_t d);
		@(posedge sys_clk);
		#1;
		csr_a = a;
		csr_we = 1'b0;
		@(posedge sys_clk);
		#1;
		d = csr_do; // registered one cycle after the address.
	endtask

	task automatic expect_reg(input logic [3:0] bank, input reg_index_t off,
			input csr_data_t exp, input string name);
		csr_data_t got;
		csr_read(reg_addr(bank, off), got);
		if (got !== exp)
			report_mismatch(name, exp, got);
	endtask

	// start n bursts and follow the strobe until it falls.
	task automatic run_bursts(input int n, input logic delayed);
		int acks;
		logic prev_ack;
		acks = 0;
		prev_ack = 1'b0;
		delay_cycles = delayed ? 3'(rand_bits(3)) : 3'd0;
		csr_write(reg_addr(BANK, `MEMTEST_REG_NBURSTS), n);
		@(negedge sys_clk);
		while (fml_stb) begin
			if (fml_ack) begin
				acks++;
				if (fml_sel !== 8'hff)
					report_mismatch("fml_sel", 8'hff, fml_sel); // no byte masking.
				if (delayed)
					delay_cycles = 3'(rand_bits(3)); // new wait for the next burst.
			end
			prev_ack = fml_ack;
			@(negedge sys_clk);
		end
		if (acks != n)
			report_mismatch("fml_ack count", n, acks);
		if (!prev_ack)
			report_failure("fml_stb fell without an ack on the cycle before");
		repeat (`MEMTEST_BURST_LEN) @(posedge sys_clk); // last beats and the compare.
	endtask

	// ------------------------------------------------------------------------
	// directed tests
	// ------------------------------------------------------------------------
	task automatic test_reset_state();
		for (int off = 0; off < 4; off++)
			expect_reg(BANK, 3'(off), '0, "csr_do");
		if (fml_stb !== 1'b0)
			report_mismatch("fml_stb", 1'b0, fml_stb);
		end_test("reset state");
	endtask

	task automatic test_write_pass(input logic delayed);
		fml_word_t d;
		adr_rand_t idx;
		// wipe the target bursts so each beat has to be written again.
		for (int b = 0; b < NB; b++) begin
			idx = burst_index(b);
			for (int k = 0; k < `MEMTEST_BURST_LEN; k++)
				fml_mem.mem[{idx, 2'(k)}] = 'x;
		end
		csr_write(reg_addr(BANK, `MEMTEST_REG_ADDRESS), ADDRESS_VALUE);
		csr_write(reg_addr(BANK, `MEMTEST_REG_WE), 32'd1);
		run_bursts(NB, delayed);
		d = `MEMTEST_DATA_SEED;
		for (int b = 0; b < NB; b++) begin
			idx = burst_index(b);
			for (int k = 0; k < `MEMTEST_BURST_LEN; k++) begin
				if (fml_mem.mem[{idx, 2'(k)}] !== d)
					report_mismatch("stored beat", d, fml_mem.mem[{idx, 2'(k)}]);
				d = next_data(d);
			end
		end
		expect_reg(BANK, `MEMTEST_REG_ADDRESS,
			csr_data_t'({ADDRESS_VALUE[25], burst_index(NB), 5'd0}), "csr_do");
		expect_reg(BANK, `MEMTEST_REG_NBURSTS, '0, "csr_do");
		end_test(delayed ? "write pass with back-pressure" : "write pass");
	endtask

	// faults is the number of beats corrupted before the pass.
	task automatic test_read_pass(input logic delayed, input int faults, input string name);
		for (int i = 0; i < faults; i++)
			fml_mem.corrupt_beat(burst_index(i * (NB - 1) / (faults - 1)), rand_bits(2));
		csr_write(reg_addr(BANK, `MEMTEST_REG_ADDRESS), ADDRESS_VALUE);
		csr_write(reg_addr(BANK, `MEMTEST_REG_WE), 32'd0);
		run_bursts(NB, delayed);
		expect_reg(BANK, `MEMTEST_REG_ERRCOUNT, faults, "csr_do");
		if (faults > 0) begin
			csr_write(reg_addr(BANK, `MEMTEST_REG_ERRCOUNT), 32'd0);
			expect_reg(BANK, `MEMTEST_REG_ERRCOUNT, '0, "csr_do");
		end
		end_test(name);
	endtask

	task automatic test_bank_decode();
		csr_data_t adr_before;
		csr_read(reg_addr(BANK, `MEMTEST_REG_ADDRESS), adr_before);
		csr_write(reg_addr(OTHER, `MEMTEST_REG_NBURSTS), 32'd5);
		csr_write(reg_addr(OTHER, `MEMTEST_REG_ADDRESS), 32'd0);
		csr_write(reg_addr(OTHER, `MEMTEST_REG_WE), 32'd1);
		@(negedge sys_clk);
		if (fml_stb !== 1'b0)
			report_failure("a write to another bank started bursts");
		expect_reg(BANK, `MEMTEST_REG_NBURSTS, '0, "csr_do");
		expect_reg(BANK, `MEMTEST_REG_ADDRESS, adr_before, "csr_do");
		expect_reg(BANK, `MEMTEST_REG_WE, '0, "csr_do");
		for (int off = 0; off < 4; off++)
			expect_reg(OTHER, 3'(off), '0, "csr_do");
		end_test("bank decode");
	endtask

	// ------------------------------------------------------------------------
	// sequence and watchdog
	// ------------------------------------------------------------------------
	initial begin
		sys_rst = 1'b1;
		csr_a = '0;
		csr_we = 1'b0;
		csr_di = '0;
		delay_cycles = 3'd0;
		repeat (5) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		test_reset_state();
		test_write_pass(1'b0);
		test_read_pass(1'b0, 0, "clean read pass");
		test_read_pass(1'b0, 3, "fault injection");
		test_write_pass(1'b1);
		test_read_pass(1'b1, 0, "read pass with back-pressure");
		test_bank_decode();
		$display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/memtest_fml_model.sv
/*
 * Behavioural FML 4x64 memory.
 * Burst-indexed store, ack after the strobe plus an extra delay,
 * read beats on the ack cycle and the three after it,
 * and a hook that flips bit 0 of one stored beat.
 */

`timescale 1ns/100ps
`default_nettype none

module memtest_fml_model (
	input logic sys_clk,
	input logic sys_rst,
	input fml_pkg::fml_adr_t fml_adr,
	input logic fml_stb,
	input logic fml_we,
	output logic fml_ack,
	output fml_pkg::fml_word_t fml_di,
	input fml_pkg::fml_word_t fml_do,
	input logic [2:0] delay_cycles
);

	import fml_pkg::*;

	fml_word_t mem [0:(1 << 22) - 1]; // {burst index, beat}.
	adr_rand_t idx; // burst in transfer.
	logic [1:0] beat; // beat of the current cycle.
	logic busy; // ack cycle plus three beats.
	logic we_q; // direction taken at the ack.
	logic ack_now;
	int wait_cnt; // idle cycles seen with the strobe high.

	initial begin
		fml_ack = 1'b0;
		fml_di = '0;
		busy = 1'b0;
		beat = 2'd0;
		wait_cnt = 0;
	end

	// fault hook, flips bit 0 of one stored beat.
	task automatic corrupt_beat(input adr_rand_t burst, input int n);
		logic [21:0] a;
		a = {burst, 2'(n)};
		mem[a] = mem[a] ^ 64'd1;
	endtask

	always @(posedge sys_clk) begin
		if (sys_rst) begin
			busy = 1'b0;
			wait_cnt = 0;
			fml_ack <= #1 1'b0;
			fml_di <= #1 '0;
		end else begin
			if (busy) begin
				if (we_q)
					mem[{idx, beat}] = fml_do; // beat of the cycle just ended.
				busy = beat != 2'd3;
				beat = beat + 2'd1;
			end
			ack_now = 1'b0;
			if (!busy && fml_stb) begin
				if (wait_cnt >= delay_cycles) begin
					ack_now = 1'b1; // accept the burst next cycle.
					busy = 1'b1;
					beat = 2'd0;
					idx = fml_adr[24:5]; // 32-byte burst index.
					we_q = fml_we;
					wait_cnt = 0;
				end else
					wait_cnt = wait_cnt + 1; // back-pressure.
			end
			fml_ack <= #1 ack_now;
			fml_di <= #1 (busy && !we_q) ? mem[{idx, beat}] : '0;
		end
	end

endmodule

`default_nettype wire

// File: source/memtest.sv
/*
 * Memory tester top level.
 * CSR bank, burst engine and read checker on one CSR
 * port and one FML 4x64 port.
 */

`timescale 1ns/100ps
`default_nettype none

`include "memtest_macros.svh"

module memtest (
	input logic sys_clk,
	input logic sys_rst,

	// configuration port.
	input csr_pkg::csr_addr_t csr_a,
	input logic csr_we,
	input csr_pkg::csr_data_t csr_di,
	output csr_pkg::csr_data_t csr_do,

	// FML 4x64 port.
	output fml_pkg::fml_adr_t fml_adr,
	output logic fml_stb,
	output logic fml_we,
	input logic fml_ack,
	input fml_pkg::fml_word_t fml_di,
	output fml_pkg::fml_sel_t fml_sel,
	output fml_pkg::fml_word_t fml_do
);

	import csr_pkg::*;
	import fml_pkg::*;

	logic load_bursts;
	logic load_address;
	logic clear_errors;
	logic write_mode;
	logic beat_valid;
	logic [`MEMTEST_FML_DEPTH-25-1:0] adr_top;
	csr_data_t burst_total;
	csr_data_t error_count;
	burst_cnt_t remaining_bursts;
	fml_word_t expected;

	assign fml_sel = '1; // every beat writes all bytes.

	memtest_regs u_regs (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.csr_a(csr_a), .csr_we(csr_we), .csr_di(csr_di), .csr_do(csr_do),
		.load_bursts(load_bursts), .burst_total(burst_total),
		.load_address(load_address), .adr_top(adr_top),
		.write_mode(write_mode), .clear_errors(clear_errors),
		.remaining_bursts(remaining_bursts), .fml_adr(fml_adr),
		.error_count(error_count)
	);

	memtest_engine u_engine (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.load_bursts(load_bursts), .burst_total(burst_total),
		.load_address(load_address), .adr_top(adr_top), .write_mode(write_mode),
		.fml_ack(fml_ack), .fml_stb(fml_stb), .fml_we(fml_we),
		.fml_adr(fml_adr), .fml_do(fml_do),
		.remaining_bursts(remaining_bursts), .expected(expected),
		.beat_valid(beat_valid)
	);

	memtest_checker u_checker (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.clear_errors(clear_errors), .write_mode(write_mode),
		.beat_valid(beat_valid), .expected(expected), .fml_di(fml_di),
		.error_count(error_count)
	);

endmodule

`default_nettype wire

// File: source/memtest_checker.sv
/*
 * Memory tester read checker.
 * Registered compare of each returned beat against the
 * expected word, and a saturating error counter.
 */

`timescale 1ns/100ps
`default_nettype none

module memtest_checker (
	input logic sys_clk,
	input logic sys_rst,

	input logic clear_errors,
	input logic write_mode,
	input logic beat_valid,
	input fml_pkg::fml_word_t expected,
	input fml_pkg::fml_word_t fml_di,

	output csr_pkg::csr_data_t error_count
);

	import csr_pkg::*;

	localparam csr_data_t ERR_MAX = '1;

	logic mismatch;
	logic read_beat;

	// compare stage.
	always_ff @(posedge sys_clk)
		mismatch <= fml_di != expected;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			read_beat <= 1'b0;
			error_count <= '0;
		end else begin
			read_beat <= beat_valid & ~write_mode; // write beats are not checked.
			if (clear_errors)
				error_count <= '0;
			else if (read_beat && mismatch && error_count != ERR_MAX)
				error_count <= error_count + 1'b1; // holds at the top.
		end
	end

endmodule

`default_nettype wire

// File: source/memtest_engine.sv
/*
 * Memory tester burst sequencer.
 * Holds the FML strobe while bursts remain, counts bursts
 * and beats, and steps the address and data generators.
 */

`timescale 1ns/100ps
`default_nettype none

`include "memtest_macros.svh"

module memtest_engine (
	input logic sys_clk,
	input logic sys_rst,

	input logic load_bursts,
	input csr_pkg::csr_data_t burst_total,
	input logic load_address,
	input logic [`MEMTEST_FML_DEPTH-25-1:0] adr_top,
	input logic write_mode,

	input logic fml_ack,
	output logic fml_stb,
	output logic fml_we,
	output fml_pkg::fml_adr_t fml_adr,
	output fml_pkg::fml_word_t fml_do,

	output fml_pkg::burst_cnt_t remaining_bursts,
	output fml_pkg::fml_word_t expected,
	output logic beat_valid
);

	import fml_pkg::*;

	// byte offset bits within one burst, 5 for 4x64.
	localparam int ADR_LSB = $clog2(`MEMTEST_BURST_LEN * $bits(fml_word_t) / 8);

	beat_cnt_t beat_cnt;
	adr_rand_t adr_rand;
	adr_rand_t adr_seed;
	fml_word_t data_word;

	// ------------------------------------------------------------------------
	// generators
	// ------------------------------------------------------------------------
	// reset parks the address sequence at zero until an address is written.
	assign adr_seed = sys_rst ? '0 : adr_rand_t'(`MEMTEST_ADR_SEED);

	memtest_prng #(.rand_t(fml_word_t)) u_data_prng (
		.sys_clk(sys_clk),
		.reload(sys_rst | load_bursts),
		.seed(fml_word_t'(`MEMTEST_DATA_SEED)),
		.step(beat_valid),
		.value(data_word)
	);

	memtest_prng #(.rand_t(adr_rand_t)) u_adr_prng (
		.sys_clk(sys_clk),
		.reload(sys_rst | load_address),
		.seed(adr_seed),
		.step(fml_ack), // one new address per accepted burst.
		.value(adr_rand)
	);

	// ------------------------------------------------------------------------
	// burst counter and strobe
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			remaining_bursts <= '0;
			fml_stb <= 1'b0;
		end else if (load_bursts) begin
			remaining_bursts <= burst_total;
			fml_stb <= burst_total != '0; // zero bursts start nothing.
		end else if (fml_ack) begin
			remaining_bursts <= remaining_bursts - 1'b1;
			if (remaining_bursts == burst_cnt_t'(1))
				fml_stb <= 1'b0; // last burst accepted.
		end
	end

	// beats after the ack cycle.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			beat_cnt <= '0;
		else if (fml_ack)
			beat_cnt <= beat_cnt_t'(`MEMTEST_BURST_LEN - 1);
		else if (beat_cnt != '0)
			beat_cnt <= beat_cnt - 1'b1;
	end

	assign beat_valid = (beat_cnt != '0) | fml_ack; // ack cycle plus three.

	// ------------------------------------------------------------------------
	// FML outputs
	// ------------------------------------------------------------------------
	assign fml_we = write_mode;
	assign fml_adr = {adr_top, adr_rand, {ADR_LSB{1'b0}}};
	assign fml_do = data_word;
	assign expected = data_word; // same sequence for write and compare.

	a_ack_in_stb: assert property (@(posedge sys_clk) disable iff (sys_rst)
		fml_ack |-> fml_stb)
		else $error("memtest_engine: ack without strobe");

	a_no_overlap: assert property (@(posedge sys_clk) disable iff (sys_rst)
		beat_cnt != '0 |-> !fml_ack)
		else $error("memtest_engine: ack during a burst");

endmodule

`default_nettype wire

// File: source/memtest_regs.sv
/*
 * Memory tester CSR bank.
 * Bank and register decode, write pulses for the engine and
 * checker, stored address top bits and mode, registered readback.
 */

`timescale 1ns/100ps
`default_nettype none

`include "memtest_macros.svh"

module memtest_regs (
	input logic sys_clk,
	input logic sys_rst,

	input csr_pkg::csr_addr_t csr_a,
	input logic csr_we,
	input csr_pkg::csr_data_t csr_di,
	output csr_pkg::csr_data_t csr_do,

	output logic load_bursts,
	output csr_pkg::csr_data_t burst_total,
	output logic load_address,
	output logic [`MEMTEST_FML_DEPTH-25-1:0] adr_top,
	output logic write_mode,
	output logic clear_errors,

	input fml_pkg::burst_cnt_t remaining_bursts,
	input fml_pkg::fml_adr_t fml_adr,
	input csr_pkg::csr_data_t error_count
);

	import csr_pkg::*;

	localparam int TOP_LSB = 25; // 20 generator bits plus 5 burst offset bits.

	logic bank_hit;
	reg_index_t reg_index;
	logic wr_strobe;

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	assign bank_hit = csr_a[13:10] == `MEMTEST_CSR_BANK;
	assign reg_index = csr_a[2:0];
	assign wr_strobe = bank_hit & csr_we;

	assign load_bursts = wr_strobe & (reg_index == `MEMTEST_REG_NBURSTS); // start a run.
	assign clear_errors = wr_strobe & (reg_index == `MEMTEST_REG_ERRCOUNT);
	assign load_address = wr_strobe & (reg_index == `MEMTEST_REG_ADDRESS); // reseed addresses.

	assign burst_total = load_bursts ? csr_di : '0; // only meaningful with the pulse.

	// ------------------------------------------------------------------------
	// configuration registers
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			adr_top <= '0;
			write_mode <= 1'b0;
		end else begin
			if (load_address)
				adr_top <= csr_di[`MEMTEST_FML_DEPTH-1:TOP_LSB]; // top bits only.
			if (wr_strobe && reg_index == `MEMTEST_REG_WE)
				write_mode <= csr_di[0];
		end
	end

	// ------------------------------------------------------------------------
	// readback, one cycle after the address
	// ------------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= '0;
		end else begin
			csr_do <= '0; // other banks and offsets read zero.
			if (bank_hit) begin
				case (reg_index)
					`MEMTEST_REG_NBURSTS: csr_do <= csr_data_t'(remaining_bursts);
					`MEMTEST_REG_ERRCOUNT: csr_do <= error_count;
					`MEMTEST_REG_ADDRESS: csr_do <= csr_data_t'(fml_adr); // live address.
					`MEMTEST_REG_WE: csr_do <= csr_data_t'(write_mode);
					default: csr_do <= '0;
				endcase
			end
		end
	end

	// the engine and checker each expect their own pulse alone.
	a_one_load: assert property (@(posedge sys_clk) disable iff (sys_rst)
		$onehot0({load_bursts, load_address, clear_errors}))
		else $error("memtest_regs: more than one load pulse");

endmodule

`default_nettype wire

// File: source/memtest_prng.sv
/*
 * Pseudo-random word generator.
 * Fibonacci LFSR as wide as rand_t, reloaded from seed
 * and stepped once per enabled cycle.
 */

`timescale 1ns/100ps
`default_nettype none

module memtest_prng #(
	parameter type rand_t = logic [63:0]
) (
	input logic sys_clk,
	input logic reload,
	input rand_t seed,
	input logic step,
	output rand_t value
);

	localparam int W = $bits(rand_t);

	// maximal-length taps for the supported widths.
	function automatic rand_t tap_mask();
		logic [63:0] m;
		m = 64'd0;
		case (W)
			64: m = (64'd1 << 63) | (64'd1 << 62) | (64'd1 << 60) | (64'd1 << 59); // 64,63,61,60.
			20: m = (64'd1 << 19) | (64'd1 << 16); // 20,17.
			default: m = 64'd0;
		endcase
		return rand_t'(m);
	endfunction

	localparam rand_t TAP_MASK = tap_mask();

	if (TAP_MASK == '0) begin : g_bad_width
		$error("memtest_prng: no taps for width %0d", W);
	end

	logic [W-1:0] state;
	logic feedback;

	assign feedback = ^(state & TAP_MASK); // xor of the tapped bits.

	always_ff @(posedge sys_clk) begin
		if (reload)
			state <= seed; // restart the sequence.
		else if (step)
			state <= {state[W-2:0], feedback}; // shift toward the msb.
	end

	assign value = state;

	// xor feedback locks up at zero, so a running sequence must stay clear of it.
	a_never_zero: assert property (@(posedge sys_clk)
		(state != '0) && !reload |=> state != '0)
		else $error("memtest_prng: state reached zero");

endmodule

`default_nettype wire

// File: source/fml_pkg.sv
/*
 * FML 4x64 port types.
 * Byte address, beat word, byte select, the random address
 * part and the burst and beat counters.
 */

`default_nettype none

`include "memtest_macros.svh"

package fml_pkg;

	typedef logic [`MEMTEST_FML_DEPTH-1:0] fml_adr_t; // byte address.
	typedef logic [63:0] fml_word_t; // one beat.
	typedef logic [7:0] fml_sel_t; // one bit per byte of a beat.

	typedef logic [19:0] adr_rand_t; // burst index drawn from the generator.
	typedef logic [1:0] beat_cnt_t; // beats still due in a burst.
	typedef logic [31:0] burst_cnt_t; // bursts still to issue.

endpackage

`default_nettype wire

// File: source/csr_pkg.sv
/*
 * CSR bus types.
 * Word address, data word and the register index
 * taken from the low address bits.
 */

`default_nettype none

package csr_pkg;

	// word address as seen on csr_a.
	typedef logic [13:0] csr_addr_t;

	// read and write data.
	typedef logic [31:0] csr_data_t;

	// register offset within a bank, csr_a[2:0].
	typedef logic [2:0] reg_index_t;

endpackage

`default_nettype wire

// File: source/memtest_macros.svh
/*
 * Memory tester build constants.
 * FML address depth, CSR bank number, register offsets,
 * burst length and the reload values of the two generators.
 */

`ifndef MEMTEST_MACROS_SVH
`define MEMTEST_MACROS_SVH

// ------------------------------------------------------------------------
// FML port
// ------------------------------------------------------------------------
`define MEMTEST_FML_DEPTH 26 // byte address width of the FML port.
`define MEMTEST_BURST_LEN 4 // 64-bit beats per burst.

// ------------------------------------------------------------------------
// CSR bank and register map
// ------------------------------------------------------------------------
`define MEMTEST_CSR_BANK 4'h0 // matched against csr_a[13:10].

`define MEMTEST_REG_NBURSTS 3'd0 // write starts a run, read gives bursts left.
`define MEMTEST_REG_ERRCOUNT 3'd1 // write clears.
`define MEMTEST_REG_ADDRESS 3'd2 // write loads top bits and restarts the sequence.
`define MEMTEST_REG_WE 3'd3 // bit 0 selects write passes.

// ------------------------------------------------------------------------
// generator seeds, both nonzero
// ------------------------------------------------------------------------
`define MEMTEST_DATA_SEED 64'h9e37_79b9_7f4a_7c15
`define MEMTEST_ADR_SEED 20'h5a3c1

`endif
